//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_gbe_cpu_attach \
		-f filelist.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/Vtb_gbe_cpu_attach); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

//--- filelist.f
hdl/gbe_cpu_pkg.sv
hdl/cpu_mem_if.sv
hdl/dual_port_ram.sv
hdl/fabric_ctrl_regs.sv
hdl/wb_attach.sv
hdl/gbe_cpu_attach_top.sv
tests/tb_gbe_cpu_attach.sv

//--- hdl/cpu_mem_if.sv
`default_nettype none

interface cpu_mem_if #(
  parameter int WIDTH = 64
) ();
  import gbe_cpu_pkg::*;

  logic [BUF_AW-1:0] addr;
  logic [WIDTH-1:0]  rd_data;
  logic [WIDTH-1:0]  wr_data;
  logic              wr_en;

  modport master (output addr, output wr_data, output wr_en, input rd_data);
  modport ram (input addr, input wr_data, input wr_en, output rd_data);
endinterface

// register block access, window already decoded
interface cfg_bus ();
  logic        wr;
  logic [3:0]  idx;
  logic [3:0]  sel;
  logic [31:0] wdata;
  logic [3:0]  rd_idx;
  logic [31:0] rdata;

  modport master (output wr, output idx, output sel, output wdata, output rd_idx,
                  input rdata);
  modport slave (input wr, input idx, input sel, input wdata, input rd_idx,
                 output rdata);
endinterface

`default_nettype wire

//--- hdl/dual_port_ram.sv
`default_nettype none

module dual_port_ram #(
  parameter int WIDTH = 64
) (
  input  wire                             wb_clk_i,
  cpu_mem_if.ram                          cpu,
  input  wire [gbe_cpu_pkg::BUF_AW-1:0]   fab_addr_i,
  input  wire [WIDTH-1:0]                 fab_wr_data_i,
  input  wire                             fab_wr_en_i,
  output logic [WIDTH-1:0]                fab_rd_data_o
);
  import gbe_cpu_pkg::*;

  logic [WIDTH-1:0] mem [2**BUF_AW];

  always_ff @(posedge wb_clk_i) begin
    if (cpu.wr_en) begin
      mem[cpu.addr] <= cpu.wr_data;
    end
    // only the rx buffer enables this one
    if (fab_wr_en_i) begin
      mem[fab_addr_i] <= fab_wr_data_i;
    end
  end

  // read before write on both ports
  always_ff @(posedge wb_clk_i) begin
    cpu.rd_data   <= mem[cpu.addr];
    fab_rd_data_o <= mem[fab_addr_i];
  end

endmodule

`default_nettype wire

//--- hdl/fabric_ctrl_regs.sv
`default_nettype none

module fabric_ctrl_regs #(
  parameter logic [47:0] FABRIC_MAC      = 48'hffff_ffff_ffff,
  parameter logic [31:0] FABRIC_IP       = 32'hffff_ffff,
  parameter logic [15:0] FABRIC_PORT     = 16'hffff,
  parameter logic [7:0]  FABRIC_GATEWAY  = 8'd0,
  parameter logic        FABRIC_ENABLE   = 1'b0,
  parameter logic [31:0] MC_RECV_IP      = 32'h0000_0000,
  parameter logic [31:0] MC_RECV_IP_MASK = 32'h0000_0000,
  parameter logic [3:0]  PREEMPHASIS     = 4'b0100,
  parameter logic [4:0]  POSTEMPHASIS    = 5'b00000,
  parameter logic [3:0]  DIFFCTRL        = 4'b1010,
  parameter logic [2:0]  RXEQMIX         = 3'b111
) (
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  cfg_bus.slave       cfg,
  output logic [7:0]  tx_size_o,
  output logic        tx_ready_o,
  input  wire         tx_done_i,
  input  wire  [7:0]  rx_size_i,
  output logic        rx_ack_o,
  output logic        soft_reset_o,
  input  wire         soft_reset_ack_i,
  input  wire  [7:0]  xaui_status_i,
  output logic        local_enable_o,
  output logic [47:0] local_mac_o,
  output logic [31:0] local_ip_o,
  output logic [15:0] local_port_o,
  output logic [7:0]  local_gateway_o,
  output logic [31:0] local_mc_ip_o,
  output logic [31:0] local_mc_mask_o,
  output logic [2:0]  mgt_rxeqmix_o,
  output logic [3:0]  mgt_txpreemphasis_o,
  output logic [4:0]  mgt_txpostemphasis_o,
  output logic [3:0]  mgt_txdiffctrl_o
);
  import gbe_cpu_pkg::*;

  logic [31:0] wr_merged;

  // bus view of one register
  function automatic logic [31:0] pack_word(input logic [3:0] idx);
    logic [31:0] w;
    w = '0;
    case (reg_index_e'(idx))
      REG_MAC_HI:       w = {16'd0, local_mac_o[47:32]};
      REG_MAC_LO:       w = local_mac_o[31:0];
      REG_GATEWAY:      w = {24'd0, local_gateway_o};
      REG_IPADDR:       w = local_ip_o;
      REG_BUFFER_SIZES: w = {8'd0, tx_size_o, 8'd0, rx_ack_o ? 8'd0 : rx_size_i};
      REG_VALID_PORTS:  w = {7'd0, soft_reset_o, 7'd0, local_enable_o, local_port_o};
      REG_XAUI_STATUS:  w = {24'd0, xaui_status_i};
      REG_PHY_CONFIG:   w = {4'd0, mgt_txdiffctrl_o, 4'd0, mgt_txpreemphasis_o,
                             3'd0, mgt_txpostemphasis_o, 5'd0, mgt_rxeqmix_o};
      REG_MC_IP:        w = local_mc_ip_o;
      REG_MC_MASK:      w = local_mc_mask_o;
      default:          w = '0;
    endcase
    return w;
  endfunction

  // selected byte lanes over the current contents
  always_comb begin
    wr_merged = pack_word(cfg.idx);
    for (int i = 0; i < 4; i++) begin
      if (cfg.sel[i]) begin
        wr_merged[8*i +: 8] = cfg.wdata[8*i +: 8];
      end
    end
  end

  assign cfg.rdata = pack_word(cfg.rd_idx);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      local_mac_o          <= FABRIC_MAC;
      local_ip_o           <= FABRIC_IP;
      local_port_o         <= FABRIC_PORT;
      local_gateway_o      <= FABRIC_GATEWAY;
      local_enable_o       <= FABRIC_ENABLE;
      local_mc_ip_o        <= MC_RECV_IP;
      local_mc_mask_o      <= MC_RECV_IP_MASK;
      mgt_txpreemphasis_o  <= PREEMPHASIS;
      mgt_txpostemphasis_o <= POSTEMPHASIS;
      mgt_txdiffctrl_o     <= DIFFCTRL;
      mgt_rxeqmix_o        <= RXEQMIX;
      tx_size_o            <= 8'd0;
      tx_ready_o           <= 1'b0;
      rx_ack_o             <= 1'b0;
      soft_reset_o         <= 1'b0;
    end else begin
      // packet sent, buffer free again
      if (tx_done_i) begin
        tx_size_o  <= 8'd0;
        tx_ready_o <= 1'b0;
      end
      // size goes to zero once the rx double buffer swaps
      if (rx_size_i == 8'd0) begin
        rx_ack_o <= 1'b0;
      end
      if (soft_reset_ack_i) begin
        soft_reset_o <= 1'b0;
      end
      if (cfg.wr) begin
        case (reg_index_e'(cfg.idx))
          REG_MAC_HI:  local_mac_o[47:32] <= wr_merged[15:0];
          REG_MAC_LO:  local_mac_o[31:0]  <= wr_merged;
          REG_GATEWAY: local_gateway_o    <= wr_merged[7:0];
          REG_IPADDR:  local_ip_o         <= wr_merged;
          REG_BUFFER_SIZES: begin
            if (cfg.sel[0] && cfg.wdata[7:0] == 8'd0) begin
              rx_ack_o <= 1'b1;
            end
            if (cfg.sel[2]) begin
              tx_size_o  <= cfg.wdata[23:16];
              tx_ready_o <= 1'b1;
            end
          end
          REG_VALID_PORTS: begin
            local_port_o   <= wr_merged[15:0];
            local_enable_o <= wr_merged[16];
            if (cfg.sel[3] && cfg.wdata[24]) begin
              soft_reset_o <= 1'b1;
            end
          end
          REG_PHY_CONFIG: begin
            mgt_rxeqmix_o        <= wr_merged[2:0];
            mgt_txpostemphasis_o <= wr_merged[12:8];
            mgt_txpreemphasis_o  <= wr_merged[19:16];
            mgt_txdiffctrl_o     <= wr_merged[27:24];
          end
          REG_MC_IP:   local_mc_ip_o   <= wr_merged;
          REG_MC_MASK: local_mc_mask_o <= wr_merged;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/gbe_cpu_attach_top.sv
`default_nettype none

module gbe_cpu_attach_top #(
  parameter logic [47:0] FABRIC_MAC      = 48'hffff_ffff_ffff,
  parameter logic [31:0] FABRIC_IP       = 32'hffff_ffff,
  parameter logic [15:0] FABRIC_PORT     = 16'hffff,
  parameter logic [7:0]  FABRIC_GATEWAY  = 8'd0,
  parameter logic        FABRIC_ENABLE   = 1'b0,
  parameter logic [31:0] MC_RECV_IP      = 32'h0000_0000,
  parameter logic [31:0] MC_RECV_IP_MASK = 32'h0000_0000,
  parameter logic [3:0]  PREEMPHASIS     = 4'b0100,
  parameter logic [4:0]  POSTEMPHASIS    = 5'b00000,
  parameter logic [3:0]  DIFFCTRL        = 4'b1010,
  parameter logic [2:0]  RXEQMIX         = 3'b111
) (
  input  wire                            wb_clk_i,
  input  wire                            wb_rst_i,
  input  wire  [31:0]                    wb_adr_i,
  input  wire  [31:0]                    wb_dat_i,
  input  wire  [3:0]                     wb_sel_i,
  input  wire                            wb_we_i,
  input  wire                            wb_cyc_i,
  input  wire                            wb_stb_i,
  output logic [31:0]                    wb_dat_o,
  output logic                           wb_ack_o,
  output logic                           wb_err_o,
  input  wire  [gbe_cpu_pkg::BUF_AW-1:0] tx_rd_addr_i,
  output logic [63:0]                    tx_rd_data_o,
  output logic [7:0]                     tx_size_o,
  output logic                           tx_ready_o,
  input  wire                            tx_done_i,
  input  wire  [gbe_cpu_pkg::BUF_AW-1:0] rx_wr_addr_i,
  input  wire  [63:0]                    rx_wr_data_i,
  input  wire                            rx_wr_en_i,
  input  wire  [7:0]                     rx_size_i,
  output logic                           rx_ack_o,
  input  wire  [gbe_cpu_pkg::BUF_AW-1:0] arp_rd_addr_i,
  output logic [47:0]                    arp_rd_data_o,
  output logic                           local_enable_o,
  output logic [47:0]                    local_mac_o,
  output logic [31:0]                    local_ip_o,
  output logic [15:0]                    local_port_o,
  output logic [7:0]                     local_gateway_o,
  output logic [31:0]                    local_mc_ip_o,
  output logic [31:0]                    local_mc_mask_o,
  output logic                           soft_reset_o,
  input  wire                            soft_reset_ack_i,
  input  wire  [7:0]                     xaui_status_i,
  output logic [2:0]                     mgt_rxeqmix_o,
  output logic [3:0]                     mgt_txpreemphasis_o,
  output logic [4:0]                     mgt_txpostemphasis_o,
  output logic [3:0]                     mgt_txdiffctrl_o
);

  cfg_bus                 cfg ();
  cpu_mem_if #(.WIDTH(64)) tx_mem ();
  cpu_mem_if #(.WIDTH(64)) rx_mem ();
  cpu_mem_if #(.WIDTH(48)) arp_mem ();

  wb_attach wb_attach_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .cfg      (cfg),
    .tx_mem   (tx_mem),
    .rx_mem   (rx_mem),
    .arp_mem  (arp_mem)
  );

  fabric_ctrl_regs #(
    .FABRIC_MAC      (FABRIC_MAC),
    .FABRIC_IP       (FABRIC_IP),
    .FABRIC_PORT     (FABRIC_PORT),
    .FABRIC_GATEWAY  (FABRIC_GATEWAY),
    .FABRIC_ENABLE   (FABRIC_ENABLE),
    .MC_RECV_IP      (MC_RECV_IP),
    .MC_RECV_IP_MASK (MC_RECV_IP_MASK),
    .PREEMPHASIS     (PREEMPHASIS),
    .POSTEMPHASIS    (POSTEMPHASIS),
    .DIFFCTRL        (DIFFCTRL),
    .RXEQMIX         (RXEQMIX)
  ) fabric_ctrl_regs_inst (
    .wb_clk_i             (wb_clk_i),
    .wb_rst_i             (wb_rst_i),
    .cfg                  (cfg),
    .tx_size_o            (tx_size_o),
    .tx_ready_o           (tx_ready_o),
    .tx_done_i            (tx_done_i),
    .rx_size_i            (rx_size_i),
    .rx_ack_o             (rx_ack_o),
    .soft_reset_o         (soft_reset_o),
    .soft_reset_ack_i     (soft_reset_ack_i),
    .xaui_status_i        (xaui_status_i),
    .local_enable_o       (local_enable_o),
    .local_mac_o          (local_mac_o),
    .local_ip_o           (local_ip_o),
    .local_port_o         (local_port_o),
    .local_gateway_o      (local_gateway_o),
    .local_mc_ip_o        (local_mc_ip_o),
    .local_mc_mask_o      (local_mc_mask_o),
    .mgt_rxeqmix_o        (mgt_rxeqmix_o),
    .mgt_txpreemphasis_o  (mgt_txpreemphasis_o),
    .mgt_txpostemphasis_o (mgt_txpostemphasis_o),
    .mgt_txdiffctrl_o     (mgt_txdiffctrl_o)
  );

  // fabric reads tx, never writes it
  dual_port_ram #(.WIDTH(64)) tx_ram (
    .wb_clk_i      (wb_clk_i),
    .cpu           (tx_mem),
    .fab_addr_i    (tx_rd_addr_i),
    .fab_wr_data_i (64'd0),
    .fab_wr_en_i   (1'b0),
    .fab_rd_data_o (tx_rd_data_o)
  );

  dual_port_ram #(.WIDTH(64)) rx_ram (
    .wb_clk_i      (wb_clk_i),
    .cpu           (rx_mem),
    .fab_addr_i    (rx_wr_addr_i),
    .fab_wr_data_i (rx_wr_data_i),
    .fab_wr_en_i   (rx_wr_en_i),
    .fab_rd_data_o ()
  );

  dual_port_ram #(.WIDTH(48)) arp_ram (
    .wb_clk_i      (wb_clk_i),
    .cpu           (arp_mem),
    .fab_addr_i    (arp_rd_addr_i),
    .fab_wr_data_i (48'd0),
    .fab_wr_en_i   (1'b0),
    .fab_rd_data_o (arp_rd_data_o)
  );

endmodule

`default_nettype wire

//--- hdl/gbe_cpu_pkg.sv
`default_nettype none

package gbe_cpu_pkg;

  // every memory holds 256 words
  localparam int BUF_AW = 8;

  // cpu byte address windows
  localparam logic [31:0] REGS_BASE  = 32'h0000_0000;
  localparam logic [31:0] REGS_HIGH  = 32'h0000_07ff;
  localparam logic [31:0] TXBUF_BASE = 32'h0000_1000;
  localparam logic [31:0] TXBUF_HIGH = 32'h0000_17ff;
  localparam logic [31:0] RXBUF_BASE = 32'h0000_2000;
  localparam logic [31:0] RXBUF_HIGH = 32'h0000_27ff;
  localparam logic [31:0] ARP_BASE   = 32'h0000_3000;
  localparam logic [31:0] ARP_HIGH   = 32'h0000_37ff;

  typedef enum logic [3:0] {
    REG_MAC_HI       = 4'd0,
    REG_MAC_LO       = 4'd1,
    REG_GATEWAY      = 4'd3,
    REG_IPADDR       = 4'd4,
    REG_BUFFER_SIZES = 4'd6,
    REG_VALID_PORTS  = 4'd8,
    REG_XAUI_STATUS  = 4'd9,
    REG_PHY_CONFIG   = 4'd10,
    REG_MC_IP        = 4'd12,
    REG_MC_MASK      = 4'd13
  } reg_index_e;

  // one buffer word, seen as byte lanes or as bus halves
  typedef union packed {
    logic [7:0][7:0] lane;
    struct packed {
      logic [31:0] upper;
      logic [31:0] lower;
    } half;
  } buf_word_u;

endpackage

`default_nettype wire

//--- hdl/wb_attach.sv
`default_nettype none

module wb_attach (
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  input  wire  [31:0] wb_adr_i,
  input  wire  [31:0] wb_dat_i,
  input  wire  [3:0]  wb_sel_i,
  input  wire         wb_we_i,
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  cfg_bus.master      cfg,
  cpu_mem_if.master   tx_mem,
  cpu_mem_if.master   rx_mem,
  cpu_mem_if.master   arp_mem
);
  import gbe_cpu_pkg::*;

  logic        ack_q;
  logic        err_q;
  logic        wait_q;
  logic        req;
  logic        in_regs;
  logic        in_tx;
  logic        in_rx;
  logic        in_arp;
  logic        use_tx_q;
  logic        use_rx_q;
  logic        use_arp_q;
  logic        lo_q;
  logic        wait_arp_q;
  logic        tx_we_q;
  logic        arp_we_q;
  logic [3:0]  rd_idx_q;
  logic [63:0] wr_word_q;
  logic [31:0] mem_half;
  buf_word_u   old_w;
  buf_word_u   merged_w;
  buf_word_u   rd_w;

  function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base,
                                     input logic [31:0] high);
    return (addr >= base) && (addr <= high);
  endfunction

  // ack, err and a pending write all mask new requests
  assign req = wb_cyc_i && wb_stb_i && !ack_q && !err_q && !wait_q;

  assign in_regs = in_window(wb_adr_i, REGS_BASE, REGS_HIGH);
  assign in_tx   = in_window(wb_adr_i, TXBUF_BASE, TXBUF_HIGH);
  assign in_rx   = in_window(wb_adr_i, RXBUF_BASE, RXBUF_HIGH);
  assign in_arp  = in_window(wb_adr_i, ARP_BASE, ARP_HIGH);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      wait_q    <= 1'b0;
      use_tx_q  <= 1'b0;
      use_rx_q  <= 1'b0;
      use_arp_q <= 1'b0;
      tx_we_q   <= 1'b0;
      arp_we_q  <= 1'b0;
    end else begin
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      tx_we_q  <= 1'b0;
      arp_we_q <= 1'b0;
      if (wait_q) begin
        // second cycle of a tx/arp write
        wait_q   <= 1'b0;
        ack_q    <= 1'b1;
        tx_we_q  <= !wait_arp_q;
        arp_we_q <= wait_arp_q;
      end else if (req) begin
        use_tx_q  <= in_tx && !wb_we_i;
        use_rx_q  <= in_rx && !wb_we_i;
        use_arp_q <= in_arp && !wb_we_i;
        if (!(in_regs || in_tx || in_rx || in_arp)) begin
          err_q <= 1'b1;
        end else if (wb_we_i && (in_tx || in_arp)) begin
          wait_q <= 1'b1;
        end else begin
          ack_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rd_idx_q   <= wb_adr_i[5:2];
      lo_q       <= wb_adr_i[2];
      wait_arp_q <= in_arp;
    end
    if (wait_q) begin
      wr_word_q <= merged_w;
    end
  end

  // old word was read on the request edge
  always_comb begin
    old_w    = wait_arp_q ? {16'd0, arp_mem.rd_data} : tx_mem.rd_data;
    merged_w = old_w;
    for (int i = 0; i < 8; i++) begin
      if (wb_sel_i[i % 4] && (lo_q == (i < 4))) begin
        merged_w.lane[i] = wb_dat_i[8*(i % 4) +: 8];
      end
    end
  end

  assign tx_mem.addr     = wb_adr_i[BUF_AW+2:3];
  assign tx_mem.wr_data  = wr_word_q;
  assign tx_mem.wr_en    = tx_we_q;
  assign arp_mem.addr    = wb_adr_i[BUF_AW+2:3];
  assign arp_mem.wr_data = wr_word_q[47:0];
  assign arp_mem.wr_en   = arp_we_q;
  // rx is filled by the fabric only
  assign rx_mem.addr     = wb_adr_i[BUF_AW+2:3];
  assign rx_mem.wr_data  = wr_word_q;
  assign rx_mem.wr_en    = 1'b0;

  assign cfg.wr     = req && in_regs && wb_we_i;
  assign cfg.idx    = wb_adr_i[5:2];
  assign cfg.sel    = wb_sel_i;
  assign cfg.wdata  = wb_dat_i;
  assign cfg.rd_idx = rd_idx_q;

  always_comb begin
    if (use_arp_q) begin
      rd_w = {16'd0, arp_mem.rd_data};
    end else if (use_rx_q) begin
      rd_w = rx_mem.rd_data;
    end else begin
      rd_w = tx_mem.rd_data;
    end
    mem_half = lo_q ? rd_w.half.lower : rd_w.half.upper;
  end

  assign wb_dat_o = !ack_q ? 32'd0 :
                    (use_tx_q || use_rx_q || use_arp_q) ? mem_half : cfg.rdata;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

endmodule

`default_nettype wire

//--- tests/tb_gbe_cpu_attach.sv
`default_nettype none

module tb_gbe_cpu_attach;
  timeunit 1ns;
  timeprecision 1ps;
  import gbe_cpu_pkg::*;

  localparam logic [47:0] P_MAC     = 48'h0260_3701_a2c4;
  localparam logic [31:0] P_IP      = 32'hc0a8_0a11;
  localparam logic [15:0] P_PORT    = 16'h2710;
  localparam logic [7:0]  P_GW      = 8'h01;
  localparam logic        P_EN      = 1'b1;
  localparam logic [31:0] P_MC_IP   = 32'he000_0001;
  localparam logic [31:0] P_MC_MASK = 32'hffff_ff00;
  localparam logic [3:0]  P_PRE     = 4'h6;
  localparam logic [4:0]  P_POST    = 5'h0b;
  localparam logic [3:0]  P_DIFF    = 4'h9;
  localparam logic [2:0]  P_RXEQ    = 3'b101;
  // roughly 220 bus transfers plus fabric accesses and reset
  localparam int NUM_XFERS      = 220;
  localparam int TIMEOUT_CYCLES = NUM_XFERS * 4 + 200;

  logic        wb_clk_i, wb_rst_i, wb_we_i, wb_cyc_i, wb_stb_i;
  logic [31:0] wb_adr_i, wb_dat_i, wb_dat_o;
  logic [3:0]  wb_sel_i;
  logic        wb_ack_o, wb_err_o;
  logic [7:0]  tx_rd_addr_i, rx_wr_addr_i, arp_rd_addr_i, rx_size_i, xaui_status_i;
  logic [63:0] tx_rd_data_o, rx_wr_data_i;
  logic [7:0]  tx_size_o, local_gateway_o;
  logic        tx_ready_o, tx_done_i, rx_wr_en_i, rx_ack_o;
  logic [47:0] arp_rd_data_o, local_mac_o;
  logic        local_enable_o, soft_reset_o, soft_reset_ack_i;
  logic [31:0] local_ip_o, local_mc_ip_o, local_mc_mask_o;
  logic [15:0] local_port_o;
  logic [2:0]  mgt_rxeqmix_o;
  logic [3:0]  mgt_txpreemphasis_o, mgt_txdiffctrl_o;
  logic [4:0]  mgt_txpostemphasis_o;
  logic        slow_wr;

  logic [31:0] lfsr = 32'hb824;
  int          cycle_cnt = 0;
  logic [31:0] reg_model [16];
  logic [31:0] reg_mask [16];
  logic [63:0] tx_model [256];
  logic [47:0] arp_model [256];
  logic [63:0] rx_model [256];
  int          wr_idx [8] = '{0, 1, 3, 4, 8, 10, 12, 13};

  gbe_cpu_attach_top #(
    .FABRIC_MAC (P_MAC), .FABRIC_IP (P_IP), .FABRIC_PORT (P_PORT),
    .FABRIC_GATEWAY (P_GW), .FABRIC_ENABLE (P_EN), .MC_RECV_IP (P_MC_IP),
    .MC_RECV_IP_MASK (P_MC_MASK), .PREEMPHASIS (P_PRE), .POSTEMPHASIS (P_POST),
    .DIFFCTRL (P_DIFF), .RXEQMIX (P_RXEQ)
  ) gbe_cpu_attach_top_inst (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run("timeout: the run did not finish within the cycle limit");
    end
  end

  // tx and arp writes need a read of the old word first
  assign slow_wr = wb_we_i && ((wb_adr_i >= TXBUF_BASE && wb_adr_i <= TXBUF_HIGH) ||
                               (wb_adr_i >= ARP_BASE && wb_adr_i <= ARP_HIGH));

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !(wb_ack_o && wb_err_o))
    else fail_run("ack and err were high together");
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                   !wb_ack_o |-> wb_dat_o == 32'd0)
    else fail_run("read data was not zero without ack");
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                   $rose(wb_stb_i) && !slow_wr |-> ##1 (wb_ack_o || wb_err_o))
    else fail_run("no response one cycle after the request");
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                   $rose(wb_stb_i) && slow_wr |-> ##1 !wb_ack_o ##1 wb_ack_o)
    else fail_run("buffer write was not acked in its second cycle");

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] dat,
                                              input logic [3:0] sel);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) r[8*i +: 8] = dat[8*i +: 8];
    end
    return r;
  endfunction

  // address bit 2 picks the lower half
  function automatic logic [63:0] merge_word(input logic [63:0] old, input logic [31:0] dat,
                                             input logic [3:0] sel, input logic lo);
    if (lo) return {old[63:32], merge_bytes(old[31:0], dat, sel)};
    return {merge_bytes(old[63:32], dat, sel), old[31:0]};
  endfunction

  function automatic logic [31:0] mem_adr(input logic [31:0] base, input logic [7:0] a,
                                          input logic lo);
    return base + {21'd0, a, 3'd0} + (lo ? 32'd4 : 32'd0);
  endfunction

  task automatic bus_xfer(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                          input logic [3:0] sel, output logic [31:0] rdata,
                          output logic got_err);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    wb_adr_i <= adr;
    wb_we_i  <= we;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    do begin
      @(negedge wb_clk_i);
      waited++;
      if (waited > 4) fail_run("bus transfer got neither ack nor err");
    end while (!wb_ack_o && !wb_err_o);
    rdata   = wb_dat_o;
    got_err = wb_err_o;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
    logic [31:0] rd;
    logic        e;
    bus_xfer(adr, 1'b1, dat, sel, rd, e);
    if (e) fail_run("write inside a window returned err");
  endtask

  task automatic read_check(input string name, input logic [31:0] adr,
                            input logic [31:0] exp);
    logic [31:0] rd;
    logic        e;
    bus_xfer(adr, 1'b0, 32'd0, 4'hf, rd, e);
    if (e) fail_run("read inside a window returned err");
    check_value(name, 64'(exp), 64'(rd));
  endtask

  task automatic expect_err(input logic [31:0] adr, input logic we);
    logic [31:0] rd;
    logic        e;
    bus_xfer(adr, we, 32'hdead_beef, 4'hf, rd, e);
    if (!e) fail_run("address outside the windows did not return err");
  endtask

  function automatic logic [31:0] reg_exp(input int idx);
    if (idx == 6) return {24'd0, rx_size_i};
    if (idx == 9) return {24'd0, xaui_status_i};
    return reg_model[idx];
  endfunction

  task automatic check_cfg_outputs(input string name);
    check_value({name, " mac"}, 64'({reg_model[0][15:0], reg_model[1]}), 64'(local_mac_o));
    check_value({name, " ip"}, 64'(reg_model[4]), 64'(local_ip_o));
    check_value({name, " gw"}, 64'(reg_model[3][7:0]), 64'(local_gateway_o));
    check_value({name, " port"}, 64'(reg_model[8][15:0]), 64'(local_port_o));
    check_value({name, " en"}, 64'(reg_model[8][16]), 64'(local_enable_o));
    check_value({name, " mc_ip"}, 64'(reg_model[12]), 64'(local_mc_ip_o));
    check_value({name, " mc_mask"}, 64'(reg_model[13]), 64'(local_mc_mask_o));
    check_value({name, " phy"}, 64'({reg_model[10][27:24], reg_model[10][19:16],
                reg_model[10][12:8], reg_model[10][2:0]}),
                64'({mgt_txdiffctrl_o, mgt_txpreemphasis_o, mgt_txpostemphasis_o,
                mgt_rxeqmix_o}));
  endtask

  task automatic fabric_read(input logic is_arp, input logic [7:0] a,
                             output logic [63:0] d);
    @(posedge wb_clk_i);
    if (is_arp) arp_rd_addr_i <= a;
    else tx_rd_addr_i <= a;
    @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    d = is_arp ? {16'd0, arp_rd_data_o} : tx_rd_data_o;
  endtask

  initial begin
    logic [31:0] v, d, hi, lo;
    logic [7:0]  a;
    logic [7:0]  tx_a;
    logic [63:0] w, fw;
    int          idx;
    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    tx_rd_addr_i = '0;
    rx_wr_addr_i = '0;
    rx_wr_data_i = '0;
    rx_wr_en_i = 1'b0;
    arp_rd_addr_i = '0;
    tx_done_i = 1'b0;
    rx_size_i = 8'h40;
    soft_reset_ack_i = 1'b0;
    xaui_status_i = 8'h5a;
    reg_model = '{default: 32'd0};
    reg_mask = '{default: 32'd0};
    reg_model[0]  = {16'd0, P_MAC[47:32]};
    reg_model[1]  = P_MAC[31:0];
    reg_model[3]  = {24'd0, P_GW};
    reg_model[4]  = P_IP;
    reg_model[8]  = {15'd0, P_EN, P_PORT};
    reg_model[10] = {4'd0, P_DIFF, 4'd0, P_PRE, 3'd0, P_POST, 5'd0, P_RXEQ};
    reg_model[12] = P_MC_IP;
    reg_model[13] = P_MC_MASK;
    reg_mask[0] = 32'h0000_ffff;
    reg_mask[1] = 32'hffff_ffff;
    reg_mask[3] = 32'h0000_00ff;
    reg_mask[4] = 32'hffff_ffff;
    reg_mask[8] = 32'h0001_ffff;
    reg_mask[10] = 32'h0f0f_1f07;
    reg_mask[12] = 32'hffff_ffff;
    reg_mask[13] = 32'hffff_ffff;
    repeat (16) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    // reset values
    for (int i = 0; i < 16; i++) begin
      read_check("reset_regs", REGS_BASE + (32'(i) << 2), reg_exp(i));
    end
    check_cfg_outputs("reset_outputs");
    check_value("reset_handshake", 64'd0,
                64'({tx_size_o, tx_ready_o, rx_ack_o, soft_reset_o}));

    // random register writes
    for (int k = 0; k < 24; k++) begin
      rand_bits(3, v);
      idx = wr_idx[v[2:0]];
      rand_bits(4, v);
      rand_bits(32, d);
      if (idx == 8) d[24] = 1'b0;
      reg_model[idx] = merge_bytes(reg_model[idx], d, v[3:0]) & reg_mask[idx];
      bus_write(REGS_BASE + (32'(idx) << 2), d, v[3:0]);
      read_check("reg_readback", REGS_BASE + (32'(idx) << 2), reg_exp(idx));
    end
    check_cfg_outputs("reg_outputs");
    read_check("reg_unmapped", REGS_BASE + 32'h38, 32'd0);

    // tx buffer, full words first so partial merges start from known data
    for (int k = 0; k < 8; k++) begin
      rand_bits(8, v);
      a = v[7:0];
      rand_bits(32, hi);
      rand_bits(32, lo);
      tx_model[a] = {hi, lo};
      bus_write(mem_adr(TXBUF_BASE, a, 1'b0), hi, 4'hf);
      bus_write(mem_adr(TXBUF_BASE, a, 1'b1), lo, 4'hf);
      for (int j = 0; j < 2; j++) begin
        rand_bits(5, v);
        rand_bits(32, d);
        tx_model[a] = merge_word(tx_model[a], d, v[3:0], v[4]);
        bus_write(mem_adr(TXBUF_BASE, a, v[4]), d, v[3:0]);
      end
      read_check("tx_upper", mem_adr(TXBUF_BASE, a, 1'b0), tx_model[a][63:32]);
      read_check("tx_lower", mem_adr(TXBUF_BASE, a, 1'b1), tx_model[a][31:0]);
      fabric_read(1'b0, a, fw);
      check_value("tx_fabric", tx_model[a], fw);
    end
    tx_a = a;

    // arp cache, upper half keeps 16 bits
    for (int k = 0; k < 6; k++) begin
      rand_bits(8, v);
      a = v[7:0];
      rand_bits(32, hi);
      rand_bits(32, lo);
      arp_model[a] = {hi[15:0], lo};
      bus_write(mem_adr(ARP_BASE, a, 1'b0), hi, 4'hf);
      bus_write(mem_adr(ARP_BASE, a, 1'b1), lo, 4'hf);
      rand_bits(5, v);
      rand_bits(32, d);
      w = merge_word({16'd0, arp_model[a]}, d, v[3:0], v[4]);
      arp_model[a] = w[47:0];
      bus_write(mem_adr(ARP_BASE, a, v[4]), d, v[3:0]);
      fabric_read(1'b1, a, fw);
      check_value("arp_fabric", {16'd0, arp_model[a]}, fw);
      read_check("arp_upper", mem_adr(ARP_BASE, a, 1'b0), {16'd0, arp_model[a][47:32]});
    end

    // rx buffer filled from the fabric side
    for (int k = 0; k < 6; k++) begin
      rand_bits(8, v);
      a = v[7:0];
      rand_bits(32, hi);
      rand_bits(32, lo);
      rx_model[a] = {hi, lo};
      @(posedge wb_clk_i);
      rx_wr_addr_i <= a;
      rx_wr_data_i <= {hi, lo};
      rx_wr_en_i   <= 1'b1;
      @(posedge wb_clk_i);
      rx_wr_en_i   <= 1'b0;
      read_check("rx_upper", mem_adr(RXBUF_BASE, a, 1'b0), rx_model[a][63:32]);
      read_check("rx_lower", mem_adr(RXBUF_BASE, a, 1'b1), rx_model[a][31:0]);
    end
    bus_write(mem_adr(RXBUF_BASE, a, 1'b1), ~lo, 4'hf);
    read_check("rx_bus_write", mem_adr(RXBUF_BASE, a, 1'b1), rx_model[a][31:0]);

    // tx size, ready and done
    bus_write(REGS_BASE + 32'h18, 32'h002a_0000, 4'b0100);
    check_value("tx_ready_set", 64'h12a, 64'({tx_ready_o, tx_size_o}));
    read_check("tx_size_read", REGS_BASE + 32'h18, 32'h002a_0040);
    @(posedge wb_clk_i);
    tx_done_i <= 1'b1;
    @(posedge wb_clk_i);
    tx_done_i <= 1'b0;
    @(negedge wb_clk_i);
    check_value("tx_done_clear", 64'h0, 64'({tx_ready_o, tx_size_o}));

    // rx ack masks the size until the fabric reports zero
    bus_write(REGS_BASE + 32'h18, 32'h0, 4'b0001);
    check_value("rx_ack_set", 64'd1, 64'(rx_ack_o));
    read_check("rx_size_masked", REGS_BASE + 32'h18, 32'h0);
    @(posedge wb_clk_i);
    rx_size_i <= 8'h00;
    @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    check_value("rx_ack_clear", 64'd0, 64'(rx_ack_o));
    @(posedge wb_clk_i);
    rx_size_i <= 8'h40;
    read_check("rx_size_back", REGS_BASE + 32'h18, 32'h0000_0040);

    // soft reset request
    bus_write(REGS_BASE + 32'h20, 32'h0100_0000, 4'b1000);
    check_value("soft_reset_set", 64'd1, 64'(soft_reset_o));
    read_check("soft_reset_read", REGS_BASE + 32'h20, reg_model[8] | 32'h0100_0000);
    @(posedge wb_clk_i);
    soft_reset_ack_i <= 1'b1;
    @(posedge wb_clk_i);
    soft_reset_ack_i <= 1'b0;
    @(negedge wb_clk_i);
    check_value("soft_reset_clear", 64'd0, 64'(soft_reset_o));

    // outside every window, the last one aliases a written tx word
    expect_err(32'h0000_4000, 1'b0);
    expect_err(32'h0000_0800, 1'b1);
    expect_err(mem_adr(TXBUF_HIGH + 32'd1, tx_a, 1'b0), 1'b1);
    read_check("err_regs", REGS_BASE, reg_model[0]);
    check_cfg_outputs("err_outputs");
    read_check("err_tx", mem_adr(TXBUF_BASE, tx_a, 1'b0), tx_model[tx_a][63:32]);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
